// ==== src/zbuf_pkg.sv ====
// command addresses are 8 bits wide, so ROWS and COLS may each be at most 256.
`default_nettype none

package zbuf_pkg;

  // ************************************************************************
  // command encoding
  // ************************************************************************

  localparam int unsigned ZBUF_ADDR_W = 8; // row or column index.

  // opcodes 6 and 7 are unused and decode as no-ops.
  typedef enum logic [2:0] {
    OP_NOP    = 3'd0,
    OP_WR_ROW = 3'd1,
    OP_WR_COL = 3'd2,
    OP_RD_ROW = 3'd3,
    OP_RD_COL = 3'd4,
    OP_CLEAR  = 3'd5
  } zbuf_op_e;

  // write data travels beside the command on its own port.
  typedef struct packed {
    zbuf_op_e               op;
    logic [ZBUF_ADDR_W-1:0] addr;
  } zbuf_cmd_t;

  // ************************************************************************
  // decode to store
  // ************************************************************************

  // at most one strobe is set per cycle.
  typedef struct packed {
    logic                   row_wr;
    logic                   col_wr;
    logic                   row_rd;
    logic                   col_rd;
    logic                   clear;
    logic [ZBUF_ADDR_W-1:0] addr;   // zero unless a read or write strobe is set.
  } zbuf_ctl_t;

endpackage : zbuf_pkg

`default_nettype wire

// ==== src/zbuf_decode.sv ====
// out-of-range commands are dropped with one err_o pulse; opcodes 6 and 7 act as NOP.
`timescale 1ns/1ps
`default_nettype none

module zbuf_decode import zbuf_pkg::*; #(
  parameter  int unsigned ROWS      = 4,
  parameter  int unsigned COLS      = 8,
  parameter  int unsigned WORD_SIZE = 16,
  localparam int unsigned VEC_N     = (ROWS > COLS) ? ROWS : COLS
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           cmd_valid_i,
  input  zbuf_cmd_t                      cmd_i,
  input  logic [VEC_N-1:0][WORD_SIZE-1:0] wdata_i,
  output zbuf_ctl_t                      ctl_o,
  output logic [VEC_N-1:0][WORD_SIZE-1:0] wdata_o,
  output logic                           row_cap_o,
  output logic                           col_cap_o,
  output logic                           err_o
);

  zbuf_ctl_t ctl_d, ctl_q;
  logic      row_op, col_op;
  logic      row_ok, col_ok;
  logic      err_d, err_q;
  logic      row_cap_q, col_cap_q;

  logic [VEC_N-1:0][WORD_SIZE-1:0] wdata_q;

  // ************************************************************************
  // command check
  // ************************************************************************

  assign row_op = cmd_valid_i && (cmd_i.op inside {OP_WR_ROW, OP_RD_ROW});
  assign col_op = cmd_valid_i && (cmd_i.op inside {OP_WR_COL, OP_RD_COL});
  assign row_ok = 32'(cmd_i.addr) < ROWS;
  assign col_ok = 32'(cmd_i.addr) < COLS;
  assign err_d  = (row_op && !row_ok) || (col_op && !col_ok);

  always_comb begin
    ctl_d = '0;
    if (cmd_valid_i && !err_d) begin
      case (cmd_i.op)
        OP_WR_ROW: begin
          ctl_d.row_wr = 1'b1;
          ctl_d.addr   = cmd_i.addr;
        end
        OP_WR_COL: begin
          ctl_d.col_wr = 1'b1;
          ctl_d.addr   = cmd_i.addr;
        end
        OP_RD_ROW: begin
          ctl_d.row_rd = 1'b1;
          ctl_d.addr   = cmd_i.addr;
        end
        OP_RD_COL: begin
          ctl_d.col_rd = 1'b1;
          ctl_d.addr   = cmd_i.addr;
        end
        OP_CLEAR:  ctl_d.clear = 1'b1; // address ignored.
        default:   ctl_d = '0;
      endcase
    end
  end

  // ************************************************************************
  // registered controls
  // ************************************************************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctl_q     <= '0;
      err_q     <= 1'b0;
      row_cap_q <= 1'b0;
      col_cap_q <= 1'b0;
    end else begin
      ctl_q     <= ctl_d;
      err_q     <= err_d;
      row_cap_q <= ctl_q.row_rd; // lines up with the sampled read address.
      col_cap_q <= ctl_q.col_rd;
    end
  end

  // write payload, only taken on accepted writes.
  always_ff @(posedge clk_i) begin
    if (ctl_d.row_wr || ctl_d.col_wr) begin
      wdata_q <= wdata_i;
    end
  end

  assign ctl_o     = ctl_q;
  assign wdata_o   = wdata_q;
  assign err_o     = err_q;
  assign row_cap_o = row_cap_q;
  assign col_cap_o = col_cap_q;

endmodule : zbuf_decode

`default_nettype wire

// ==== src/zbuf_store.sv ====
// flip-flop tile; ctl_i addresses must already be in range, ROWS and COLS at most 256.
`timescale 1ns/1ps
`default_nettype none

module zbuf_store import zbuf_pkg::*; #(
  parameter  int unsigned WORD_SIZE = 16,
  parameter  int unsigned ROWS      = 4,
  parameter  int unsigned COLS      = 8,
  localparam int unsigned VEC_N     = (ROWS > COLS) ? ROWS : COLS
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  zbuf_ctl_t                       ctl_i,
  input  logic [VEC_N-1:0][WORD_SIZE-1:0] wdata_i,
  output logic [COLS-1:0][WORD_SIZE-1:0]  row_rdata_o,
  output logic [ROWS-1:0][WORD_SIZE-1:0]  col_rdata_o
);

  localparam int unsigned RA_W = (ROWS > 1) ? $clog2(ROWS) : 1;
  localparam int unsigned CA_W = (COLS > 1) ? $clog2(COLS) : 1;

  logic [ROWS-1:0][COLS-1:0][WORD_SIZE-1:0] tile_q;

  // pending write.
  logic [VEC_N-1:0][WORD_SIZE-1:0] wdata_q;
  logic [ZBUF_ADDR_W-1:0]          waddr_q;
  logic                            row_wr_q;
  logic                            col_wr_q;
  logic                            clear_q;

  logic [RA_W-1:0] row_raddr_q;
  logic [CA_W-1:0] col_raddr_q;

  // ************************************************************************
  // control sampling
  // ************************************************************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_wr_q <= 1'b0;
      col_wr_q <= 1'b0;
      clear_q  <= 1'b0;
    end else begin
      row_wr_q <= ctl_i.row_wr;
      col_wr_q <= ctl_i.col_wr;
      clear_q  <= ctl_i.clear;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctl_i.row_wr || ctl_i.col_wr) begin
      wdata_q <= wdata_i;
      waddr_q <= ctl_i.addr;
    end
  end

  // a read sampled with a clear is the newer command and wins.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_raddr_q <= '0;
    end else if (ctl_i.row_rd) begin
      row_raddr_q <= ctl_i.addr[RA_W-1:0];
    end else if (clear_q) begin
      row_raddr_q <= '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      col_raddr_q <= '0;
    end else if (ctl_i.col_rd) begin
      col_raddr_q <= ctl_i.addr[CA_W-1:0];
    end else if (clear_q) begin
      col_raddr_q <= '0;
    end
  end

  // ************************************************************************
  // tile
  // ************************************************************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tile_q <= '0;
    end else if (clear_q) begin
      tile_q <= '0;
    end else begin
      for (int unsigned r = 0; r < ROWS; r++) begin
        for (int unsigned c = 0; c < COLS; c++) begin
          if (row_wr_q && (32'(waddr_q) == r)) begin
            tile_q[r][c] <= wdata_q[c];  // lowest COLS words.
          end else if (col_wr_q && (32'(waddr_q) == c)) begin
            tile_q[r][c] <= wdata_q[r];  // lowest ROWS words.
          end
        end
      end
    end
  end

  // read vectors follow the sampled addresses.
  always_comb begin
    for (int unsigned c = 0; c < COLS; c++) begin
      row_rdata_o[c] = tile_q[row_raddr_q][c];
    end
  end

  always_comb begin
    for (int unsigned r = 0; r < ROWS; r++) begin
      col_rdata_o[r] = tile_q[r][col_raddr_q];
    end
  end

endmodule : zbuf_store

`default_nettype wire

// ==== src/zbuf_result.sv ====
// output register without back-pressure; a capture not taken by the sink is lost.
`timescale 1ns/1ps
`default_nettype none

module zbuf_result #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     cap_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= cap_i; // one cycle per capture.
    end
  end

  // held until the next capture.
  always_ff @(posedge clk_i) begin
    if (cap_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule : zbuf_result

`default_nettype wire

// ==== src/zbuf_top.sv ====
// fixed two-cycle read latency, no stall; ROWS and COLS at most 256 each.
`timescale 1ns/1ps
`default_nettype none

module zbuf_top import zbuf_pkg::*; #(
  parameter  int unsigned ROWS      = 4,
  parameter  int unsigned COLS      = 8,
  parameter  int unsigned WORD_SIZE = 16,
  localparam int unsigned VEC_N     = (ROWS > COLS) ? ROWS : COLS
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            cmd_valid_i,
  input  zbuf_cmd_t                       cmd_i,
  input  logic [VEC_N-1:0][WORD_SIZE-1:0] wdata_i,
  output logic                            row_valid_o,
  output logic [COLS-1:0][WORD_SIZE-1:0]  row_rdata_o,
  output logic                            col_valid_o,
  output logic [ROWS-1:0][WORD_SIZE-1:0]  col_rdata_o,
  output logic                            err_o
);

  typedef logic [COLS-1:0][WORD_SIZE-1:0] row_vec_t;
  typedef logic [ROWS-1:0][WORD_SIZE-1:0] col_vec_t;

  zbuf_ctl_t ctl;
  logic      row_cap;
  logic      col_cap;
  row_vec_t  row_vec;
  col_vec_t  col_vec;

  logic [VEC_N-1:0][WORD_SIZE-1:0] wdata_reg;

  // ************************************************************************
  // decode and storage
  // ************************************************************************

  zbuf_decode #(
    .ROWS      ( ROWS      ),
    .COLS      ( COLS      ),
    .WORD_SIZE ( WORD_SIZE )
  ) i_decode (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .cmd_valid_i ( cmd_valid_i ),
    .cmd_i       ( cmd_i       ),
    .wdata_i     ( wdata_i     ),
    .ctl_o       ( ctl         ),
    .wdata_o     ( wdata_reg   ),
    .row_cap_o   ( row_cap     ),
    .col_cap_o   ( col_cap     ),
    .err_o       ( err_o       )
  );

  zbuf_store #(
    .WORD_SIZE ( WORD_SIZE ),
    .ROWS      ( ROWS      ),
    .COLS      ( COLS      )
  ) i_store (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .ctl_i       ( ctl       ),
    .wdata_i     ( wdata_reg ),
    .row_rdata_o ( row_vec   ),
    .col_rdata_o ( col_vec   )
  );

  // ************************************************************************
  // result stages
  // ************************************************************************

  zbuf_result #(
    .payload_t ( row_vec_t )
  ) i_row_result (
    .clk_i   ( clk_i       ),
    .rst_ni  ( rst_ni      ),
    .cap_i   ( row_cap     ),
    .data_i  ( row_vec     ),
    .valid_o ( row_valid_o ),
    .data_o  ( row_rdata_o )
  );

  zbuf_result #(
    .payload_t ( col_vec_t )
  ) i_col_result (
    .clk_i   ( clk_i       ),
    .rst_ni  ( rst_ni      ),
    .cap_i   ( col_cap     ),
    .data_i  ( col_vec     ),
    .valid_o ( col_valid_o ),
    .data_o  ( col_rdata_o )
  );

endmodule : zbuf_top

`default_nettype wire

// ==== dv/zbuf_checker.sv ====
// reference model of the tile; assumes one command per cycle and fixed DUT latencies of 1 and 2.
`timescale 1ns/1ps
`default_nettype none

module zbuf_checker import zbuf_pkg::*; #(
  parameter  int unsigned ROWS      = 4,
  parameter  int unsigned COLS      = 8,
  parameter  int unsigned WORD_SIZE = 16,
  localparam int unsigned VEC_N     = (ROWS > COLS) ? ROWS : COLS
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            cmd_valid_i,
  input  zbuf_cmd_t                       cmd_i,
  input  logic [VEC_N-1:0][WORD_SIZE-1:0] wdata_i,
  input  logic                            row_valid_i,
  input  logic [COLS-1:0][WORD_SIZE-1:0]  row_rdata_i,
  input  logic                            col_valid_i,
  input  logic [ROWS-1:0][WORD_SIZE-1:0]  col_rdata_i,
  input  logic                            err_i,
  output int unsigned                     error_count_o,
  output int unsigned                     check_count_o
);

  typedef logic [VEC_N-1:0][WORD_SIZE-1:0] wvec_t;
  typedef struct packed {
    logic                          valid;
    logic [COLS-1:0][WORD_SIZE-1:0] data;
  } row_exp_t;
  typedef struct packed {
    logic                          valid;
    logic [ROWS-1:0][WORD_SIZE-1:0] data;
  } col_exp_t;

  logic [WORD_SIZE-1:0] tile_model [ROWS][COLS];
  row_exp_t             row_pipe [3]; // index 2 is due in the current cycle.
  col_exp_t             col_pipe [3];
  logic                 err_exp;
  logic                 live;         // set at the first rising edge out of reset.
  logic                 row_seen;
  logic                 col_seen;
  logic [COLS-1:0][WORD_SIZE-1:0] row_held; // last row result, kept until the next read.
  logic [ROWS-1:0][WORD_SIZE-1:0] col_held;
  int unsigned          errors = 0;
  int unsigned          checks = 0;

  // ************************************************************************
  // model update, one command per rising edge
  // ************************************************************************

  task automatic clear_model();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        tile_model[r][c] = '0;
      end
    end
  endtask

  task automatic apply_command(input zbuf_cmd_t cmd, input wvec_t wdata);
    int unsigned a;
    a = cmd.addr;
    case (cmd.op)
      OP_WR_ROW: begin
        if (a < ROWS) begin
          for (int c = 0; c < COLS; c++) tile_model[a][c] = wdata[c];
        end else err_exp = 1'b1;
      end
      OP_WR_COL: begin
        if (a < COLS) begin
          for (int r = 0; r < ROWS; r++) tile_model[r][a] = wdata[r];
        end else err_exp = 1'b1;
      end
      OP_RD_ROW: begin
        if (a < ROWS) begin
          row_pipe[0].valid = 1'b1;
          for (int c = 0; c < COLS; c++) row_pipe[0].data[c] = tile_model[a][c];
        end else err_exp = 1'b1;
      end
      OP_RD_COL: begin
        if (a < COLS) begin
          col_pipe[0].valid = 1'b1;
          for (int r = 0; r < ROWS; r++) col_pipe[0].data[r] = tile_model[r][a];
        end else err_exp = 1'b1;
      end
      OP_CLEAR: clear_model();
      default: ; // nop.
    endcase
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      clear_model();
      for (int i = 0; i < 3; i++) begin
        row_pipe[i] = '0;
        col_pipe[i] = '0;
      end
      err_exp = 1'b0;
      live    = 1'b0;
    end else begin
      row_pipe[2] = row_pipe[1];
      row_pipe[1] = row_pipe[0];
      row_pipe[0] = '0;
      col_pipe[2] = col_pipe[1];
      col_pipe[1] = col_pipe[0];
      col_pipe[0] = '0;
      err_exp     = 1'b0;
      live        = 1'b1;
      if (cmd_valid_i) apply_command(cmd_i, wdata_i);
    end
  end

  // ************************************************************************
  // comparison, mid-cycle while outputs are stable
  // ************************************************************************

  always @(negedge clk_i) begin
    if (!live) begin
      row_seen = 1'b0;
      col_seen = 1'b0;
    end else begin
      checks++;
      if (err_i !== err_exp) begin
        errors++;
        if (err_exp) $display("%0t: expected an err_o pulse, none came", $time);
        else $display("%0t: err_o pulsed for a legal command", $time);
      end
      if (row_valid_i !== row_pipe[2].valid) begin
        errors++;
        if (row_pipe[2].valid) $display("%0t: row read result is missing", $time);
        else $display("%0t: row_valid_o pulsed with no row read pending", $time);
      end else if (row_pipe[2].valid) begin
        checks++;
        if (row_rdata_i !== row_pipe[2].data) begin
          errors++;
          $display("[ERROR] %0t: row data expected %h, got %h", $time,
                   row_pipe[2].data, row_rdata_i);
        end
      end else if (row_seen) begin
        checks++;
        if (row_rdata_i !== row_held) begin
          errors++;
          $display("[ERROR] %0t: row data changed without a read, expected %h, got %h",
                   $time, row_held, row_rdata_i);
        end
      end
      if (row_pipe[2].valid) begin
        row_held = row_pipe[2].data;
        row_seen = 1'b1;
      end
      if (col_valid_i !== col_pipe[2].valid) begin
        errors++;
        if (col_pipe[2].valid) $display("%0t: column read result is missing", $time);
        else $display("%0t: col_valid_o pulsed with no column read pending", $time);
      end else if (col_pipe[2].valid) begin
        checks++;
        if (col_rdata_i !== col_pipe[2].data) begin
          errors++;
          $display("[ERROR] %0t: column data expected %h, got %h", $time,
                   col_pipe[2].data, col_rdata_i);
        end
      end else if (col_seen) begin
        checks++;
        if (col_rdata_i !== col_held) begin
          errors++;
          $display("[ERROR] %0t: column data changed without a read, expected %h, got %h",
                   $time, col_held, col_rdata_i);
        end
      end
      if (col_pipe[2].valid) begin
        col_held = col_pipe[2].data;
        col_seen = 1'b1;
      end
    end
  end

  assign error_count_o = errors;
  assign check_count_o = checks;

endmodule : zbuf_checker

`default_nettype wire

// ==== dv/tb_zbuf.sv ====
// drives one command per cycle on the falling edge; needs ROWS and COLS below 256 for the range tests.
`timescale 1ns/1ps
`default_nettype none

module tb_zbuf import zbuf_pkg::*; #(
  parameter  int unsigned ROWS      = 4,
  parameter  int unsigned COLS      = 8,
  parameter  int unsigned WORD_SIZE = 16,
  localparam int unsigned VEC_N     = (ROWS > COLS) ? ROWS : COLS
) ();

  typedef logic [VEC_N-1:0][WORD_SIZE-1:0] wvec_t;

  localparam int unsigned N_RAND  = 400;
  localparam int unsigned N_TESTS = 6;
  localparam int unsigned N_CMDS  = 2 * ROWS + (COLS + ROWS) + 10 + (8 + ROWS) + 16 + N_RAND;
  localparam int unsigned TIMEOUT_CYCLES = N_CMDS + 20 * N_TESTS;

  logic                           clk;
  logic                           rst_n;
  logic                           cmd_valid;
  zbuf_cmd_t                      cmd;
  wvec_t                          wdata;
  logic                           row_valid, col_valid, err;
  logic [COLS-1:0][WORD_SIZE-1:0] row_rdata;
  logic [ROWS-1:0][WORD_SIZE-1:0] col_rdata;
  int unsigned                    error_count, check_count;
  int unsigned                    cycles = 0;
  int unsigned                    test_idx = 0;
  int unsigned                    failed_tests = 0;
  int unsigned                    errors_before = 0;

  zbuf_top #(.ROWS(ROWS), .COLS(COLS), .WORD_SIZE(WORD_SIZE)) UUT (
    .clk_i(clk), .rst_ni(rst_n), .cmd_valid_i(cmd_valid), .cmd_i(cmd), .wdata_i(wdata),
    .row_valid_o(row_valid), .row_rdata_o(row_rdata), .col_valid_o(col_valid),
    .col_rdata_o(col_rdata), .err_o(err)
  );

  zbuf_checker #(.ROWS(ROWS), .COLS(COLS), .WORD_SIZE(WORD_SIZE)) i_checker (
    .clk_i(clk), .rst_ni(rst_n), .cmd_valid_i(cmd_valid), .cmd_i(cmd), .wdata_i(wdata),
    .row_valid_i(row_valid), .row_rdata_i(row_rdata), .col_valid_i(col_valid),
    .col_rdata_i(col_rdata), .err_i(err), .error_count_o(error_count),
    .check_count_o(check_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the test sequence did not complete", cycles);
      $display("Something failed");
      $finish;
    end
  end

  // ************************************************************************
  // stimulus helpers
  // ************************************************************************

  function automatic wvec_t random_vec();
    wvec_t v;
    for (int i = 0; i < VEC_N; i++) v[i] = WORD_SIZE'($urandom);
    return v;
  endfunction

  task automatic send_cmd(input zbuf_op_e op, input int unsigned addr, input wvec_t data);
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd.op    = op;
    cmd.addr  = ZBUF_ADDR_W'(addr);
    wdata     = data;
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    cmd_valid = 1'b0;
    cmd       = '0;
  endtask

  // read latency is two cycles, so four idle cycles empty the pipeline.
  task automatic end_test(input string name);
    int unsigned n;
    repeat (4) idle_cycle();
    @(posedge clk);
    n = error_count - errors_before;
    test_idx++;
    if (n != 0) failed_tests++;
    $display("test %0d, %s: %s, %0d mismatches", test_idx, name, (n == 0) ? "pass" : "FAIL", n);
    errors_before = error_count;
  endtask

  // ************************************************************************
  // test sequence
  // ************************************************************************

  initial begin
    int unsigned seed_ret, r, c, a;
    zbuf_op_e    op;
    seed_ret  = $urandom(32'h3f07);
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    wdata     = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < ROWS; i++) send_cmd(OP_WR_ROW, i, random_vec());
    for (int i = 0; i < ROWS; i++) send_cmd(OP_RD_ROW, i, '0);
    end_test("row write and read");

    for (int i = 0; i < COLS; i++) send_cmd(OP_WR_COL, i, random_vec());
    for (int i = 0; i < ROWS; i++) send_cmd(OP_RD_ROW, i, '0); // transposed.
    end_test("column write, row read");

    send_cmd(OP_CLEAR, 0, '0);
    repeat (3) send_cmd(OP_RD_ROW, $urandom_range(0, ROWS - 1), '0);
    repeat (3) send_cmd(OP_RD_COL, $urandom_range(0, COLS - 1), '0);
    r = $urandom_range(0, ROWS - 1);
    send_cmd(OP_WR_ROW, r, random_vec());
    send_cmd(OP_RD_ROW, r, '0);
    send_cmd(OP_RD_COL, $urandom_range(0, COLS - 1), '0);
    end_test("clear");

    send_cmd(OP_WR_ROW, ROWS, random_vec());
    send_cmd(OP_WR_COL, COLS, random_vec());
    send_cmd(OP_RD_ROW, ROWS, '0);
    send_cmd(OP_RD_COL, COLS, '0);
    send_cmd(OP_WR_ROW, 255, random_vec());
    send_cmd(OP_WR_COL, 255, random_vec());
    send_cmd(OP_RD_ROW, $urandom_range(ROWS, 255), '0);
    send_cmd(OP_RD_COL, $urandom_range(COLS, 255), '0);
    for (int i = 0; i < ROWS; i++) send_cmd(OP_RD_ROW, i, '0);
    end_test("out of range addresses");

    repeat (4) begin
      r = $urandom_range(0, ROWS - 1);
      c = $urandom_range(0, COLS - 1);
      send_cmd(OP_WR_ROW, r, random_vec());
      send_cmd(OP_RD_COL, c, '0);   // crosses the new row at r.
      send_cmd(OP_WR_COL, c, random_vec());
      send_cmd(OP_RD_ROW, r, '0);
    end
    end_test("read right after write");

    repeat (N_RAND) begin
      if ($urandom_range(0, 4) == 0) begin
        idle_cycle();
      end else begin
        op = zbuf_op_e'(3'($urandom_range(0, 5)));
        if ($urandom_range(0, 9) == 0) a = $urandom_range(0, 255);
        else a = $urandom_range(0, VEC_N - 1);
        send_cmd(op, a, random_vec());
      end
    end
    end_test("random commands");

    $display("%0d tests run, %0d failed, %0d checks, %0d mismatches",
             test_idx, failed_tests, check_count, error_count);
    if (failed_tests == 0 && error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : tb_zbuf

`default_nettype wire

// ==== list.f ====
src/zbuf_pkg.sv
src/zbuf_decode.sv
src/zbuf_store.sv
src/zbuf_result.sv
src/zbuf_top.sv
dv/zbuf_checker.sv
dv/tb_zbuf.sv

// ==== Bender.yml ====
package:
  name: zbuf

sources:
  - src/zbuf_pkg.sv
  - src/zbuf_decode.sv
  - src/zbuf_store.sv
  - src/zbuf_result.sv
  - src/zbuf_top.sv
  - target: simulation
    files:
      - dv/zbuf_checker.sv
      - dv/tb_zbuf.sv
